/* common/streamer_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the load streamer
// Word addresses only; memory reads are whole WORD_W words
// Source words hold one FP32 element or two FP16 elements, low half first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package streamer_pkg;

  // Word address width
  localparam int unsigned ADDR_W = 16;
  // Memory and stream data width
  localparam int unsigned WORD_W = 32;
  // Job word count width
  localparam int unsigned LEN_W  = 8;

  // Source element format of a job
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fmt_e;

  // One load job
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride;
    logic [LEN_W-1:0]  len;
    fmt_e              fmt;
  } lane_job_t;

  // Read request, address only
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

  // Read response
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] rdata;
  } mem_rsp_t;

  // Two FP16 elements packed in one word
  // lo sits in bits 15:0 and leaves first
  typedef struct packed {
    logic [WORD_W/2-1:0] hi;
    logic [WORD_W/2-1:0] lo;
  } fp16_pair_t;

  // Source word seen either as FP32 or as an FP16 pair
  typedef union packed {
    logic [WORD_W-1:0] fp32;
    fp16_pair_t        fp16;
  } src_word_u;

  // One stream beat
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } beat_t;

endpackage : streamer_pkg

/* load/fp_castin.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FP16 to FP32 input cast, purely combinational
// Subnormal inputs flush to a signed zero
// NaN payload is kept, shifted into the FP32 mantissa
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fp_castin (
  input  logic [15:0] half_i,
  output logic [31:0] word_o
);

  // FP16 fields
  logic       sign;
  logic [4:0] exp_h;
  logic [9:0] man_h;

  assign sign  = half_i[15];
  assign exp_h = half_i[14:10];
  assign man_h = half_i[9:0];

  always_comb begin
    if (exp_h == 5'd0) begin
      // Zero and subnormal
      word_o = {sign, 31'd0};
    end else if (exp_h == 5'h1f) begin
      // Infinity, or NaN with its payload moved up
      word_o = {sign, 8'hff, man_h, 13'd0};
    end else begin
      // Bias 15 to bias 127
      word_o = {sign, {3'd0, exp_h} + 8'd112, man_h, 13'd0};
    end
  end

endmodule : fp_castin

/* load/lane_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Response word FIFO of one lane
// LANE_FIFO_DEPTH must be a power of two, at least 2
// Head is read combinationally from storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module lane_fifo
  import streamer_pkg::*;
#(
  parameter int unsigned LANE_FIFO_DEPTH = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   push_i,
  input  src_word_u                              data_i,
  input  logic                                   pop_i,
  output src_word_u                              data_o,
  output logic                                   empty_o,
  output logic [$clog2(LANE_FIFO_DEPTH + 1)-1:0] count_o
);

  localparam int unsigned PTR_W = $clog2(LANE_FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(LANE_FIFO_DEPTH + 1);

  src_word_u        mem_q [LANE_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Pointers wrap on the power of two depth
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (cnt_q == '0);
  assign count_o = cnt_q;

  a_no_overflow : assert property (@(posedge clk_i) disable iff (rst_i)
    push_i |-> cnt_q != CNT_W'(LANE_FIFO_DEPTH));

  a_no_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> cnt_q != '0);

endmodule : lane_fifo

/* load/load_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One load lane: address generation, slot credits and FP16 splitting
// A job with len zero finishes at once with no beats
// Start is taken only while the lane is idle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module load_lane
  import streamer_pkg::*;
#(
  parameter int unsigned LANE_FIFO_DEPTH = 4
) (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      start_i,
  input  lane_job_t job_i,
  output mem_req_t  req_o,
  output logic      req_valid_o,
  input  logic      gnt_i,
  input  mem_rsp_t  rsp_i,
  output beat_t     beat_o,
  input  logic      pop_i,
  output logic      done_o
);

  localparam int unsigned CNT_W = $clog2(LANE_FIFO_DEPTH + 1);

  logic              busy_q;
  logic              done_q;
  fmt_e              fmt_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] stride_q;
  logic [LEN_W-1:0]  issue_left_q;
  // FP16 jobs emit two elements per word
  logic [LEN_W:0]    elem_left_q;
  logic              half_q;
  logic [CNT_W-1:0]  inflight_q;

  logic [CNT_W-1:0]  fifo_cnt;
  logic              fifo_empty;
  src_word_u         head;
  logic [CNT_W:0]    used;
  logic              has_slot;
  logic              word_pop;
  logic [15:0]       half_sel;
  logic [WORD_W-1:0] cast_word;

  // Slots taken by stored words and reads in flight
  assign used     = {1'b0, fifo_cnt} + {1'b0, inflight_q};
  assign has_slot = used < (CNT_W + 1)'(LANE_FIFO_DEPTH);

  assign req_valid_o = busy_q && (issue_left_q != '0) && has_slot;
  assign req_o.addr  = addr_q;

  // FP16 head word is released after its high half
  assign word_pop = pop_i && ((fmt_q == FMT_FP32) || half_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      fmt_q        <= FMT_FP32;
      issue_left_q <= '0;
      elem_left_q  <= '0;
      half_q       <= 1'b0;
      inflight_q   <= '0;
    end else begin
      inflight_q <= inflight_q + CNT_W'(gnt_i) - CNT_W'(rsp_i.valid);
      if (start_i && !busy_q) begin
        busy_q       <= (job_i.len != '0);
        done_q       <= (job_i.len == '0);
        fmt_q        <= job_i.fmt;
        issue_left_q <= job_i.len;
        elem_left_q  <= (job_i.fmt == FMT_FP16) ? {job_i.len, 1'b0} : {1'b0, job_i.len};
        half_q       <= 1'b0;
      end else begin
        if (gnt_i) begin
          issue_left_q <= issue_left_q - 1'b1;
        end
        if (pop_i) begin
          elem_left_q <= elem_left_q - 1'b1;
          half_q      <= (fmt_q == FMT_FP16) && !half_q;
          // Last element taken, done shows next cycle
          if (elem_left_q == (LEN_W + 1)'(1)) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  // Address walk, payload only
  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      addr_q   <= job_i.base;
      stride_q <= job_i.stride;
    end else if (gnt_i) begin
      addr_q <= addr_q + stride_q;
    end
  end

  lane_fifo #(
    .LANE_FIFO_DEPTH ( LANE_FIFO_DEPTH )
  ) u_lane_fifo (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .push_i  ( rsp_i.valid ),
    .data_i  ( rsp_i.rdata ),
    .pop_i   ( word_pop    ),
    .data_o  ( head        ),
    .empty_o ( fifo_empty  ),
    .count_o ( fifo_cnt    )
  );

  // Low half first, then high half
  assign half_sel = half_q ? head.fp16.hi : head.fp16.lo;

  fp_castin u_fp_castin (
    .half_i ( half_sel  ),
    .word_o ( cast_word )
  );

  assign beat_o.valid = !fifo_empty;
  assign beat_o.data  = (fmt_q == FMT_FP16) ? cast_word : head.fp32;
  assign done_o       = done_q;

  // Grants from the arbiter and FIFO pushes never overbook the slots
  a_slots_ok : assert property (@(posedge clk_i) disable iff (rst_i)
    used <= (CNT_W + 1)'(LANE_FIFO_DEPTH));

endmodule : load_lane

/* verilog/mem_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin read arbiter with in-order response routing
// MAX_OUTSTANDING must be a power of two
// Lanes must hold request and valid until granted
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mem_arbiter
  import streamer_pkg::*;
#(
  parameter int unsigned NUM_LANES       = 3,
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mem_req_t [NUM_LANES-1:0] lane_req_i,
  input  logic     [NUM_LANES-1:0] lane_req_valid_i,
  output logic     [NUM_LANES-1:0] lane_gnt_o,
  output mem_rsp_t [NUM_LANES-1:0] lane_rsp_o,
  output mem_req_t                 mem_req_o,
  output logic                     mem_req_valid_o,
  input  logic                     mem_gnt_i,
  input  mem_rsp_t                 mem_rsp_i
);

  localparam int unsigned IDX_W  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int unsigned OPTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned OCNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [IDX_W-1:0]  rr_q;
  logic [IDX_W-1:0]  pick;
  logic [IDX_W-1:0]  sel;
  logic              hold_q;
  logic [IDX_W-1:0]  held_sel_q;
  logic              accept;

  // Lane index FIFO, one entry per read in flight
  logic [IDX_W-1:0]  idx_mem [MAX_OUTSTANDING];
  logic [OPTR_W-1:0] idx_wr_q;
  logic [OPTR_W-1:0] idx_rd_q;
  logic [OCNT_W-1:0] idx_cnt_q;
  logic              idx_full;
  logic [IDX_W-1:0]  idx_head;

  // First requesting lane at or after rr_q
  // Walk backwards so the nearest lane is written last
  always_comb begin
    int unsigned cand;
    pick = rr_q;
    for (int k = NUM_LANES - 1; k >= 0; k--) begin
      cand = int'(rr_q) + k;
      if (cand >= NUM_LANES) begin
        cand = cand - NUM_LANES;
      end
      if (lane_req_valid_i[cand]) begin
        pick = IDX_W'(cand);
      end
    end
  end

  // A stalled request stays on the same lane
  assign sel      = hold_q ? held_sel_q : pick;
  assign idx_full = (idx_cnt_q == OCNT_W'(MAX_OUTSTANDING));
  assign idx_head = idx_mem[idx_rd_q];

  // No new read while the index FIFO is full
  assign mem_req_valid_o = lane_req_valid_i[sel] && !idx_full;
  assign mem_req_o       = lane_req_i[sel];
  assign accept          = mem_req_valid_o && mem_gnt_i;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_gnt_o[i]       = accept && (sel == IDX_W'(i));
      // Oldest index owns the response
      lane_rsp_o[i].valid = mem_rsp_i.valid && (idx_head == IDX_W'(i));
      lane_rsp_o[i].rdata = mem_rsp_i.rdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q      <= '0;
      hold_q    <= 1'b0;
      idx_wr_q  <= '0;
      idx_rd_q  <= '0;
      idx_cnt_q <= '0;
    end else begin
      hold_q <= mem_req_valid_o && !mem_gnt_i;
      // Priority moves past the lane just served
      if (accept) begin
        rr_q     <= (sel == IDX_W'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
        idx_wr_q <= idx_wr_q + 1'b1;
      end
      if (mem_rsp_i.valid) begin
        idx_rd_q <= idx_rd_q + 1'b1;
      end
      idx_cnt_q <= idx_cnt_q + OCNT_W'(accept) - OCNT_W'(mem_rsp_i.valid);
    end
  end

  // Index storage and held lane
  always_ff @(posedge clk_i) begin
    held_sel_q <= sel;
    if (accept) begin
      idx_mem[idx_wr_q] <= sel;
    end
  end

  // Every response belongs to a read accepted earlier
  a_rsp_has_owner : assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rsp_i.valid |-> idx_cnt_q != '0);

  // Memory side rule, relies on the lanes holding their requests
  a_req_held : assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_gnt_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule : mem_arbiter

/* verilog/stream_egress.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-lane output credit gate and output registers
// Each lane starts with OUT_CREDITS credits after reset
// Consumer must not return more credits than beats it received
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module stream_egress
  import streamer_pkg::*;
#(
  parameter int unsigned NUM_LANES   = 3,
  parameter int unsigned OUT_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  beat_t [NUM_LANES-1:0] beat_i,
  output logic  [NUM_LANES-1:0] pop_o,
  output beat_t [NUM_LANES-1:0] stream_o,
  input  logic  [NUM_LANES-1:0] credit_i
);

  localparam int unsigned CRED_W = $clog2(OUT_CREDITS + 1);

  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    logic [CRED_W-1:0] cred_q;
    logic              valid_q;
    logic [WORD_W-1:0] data_q;

    // Take a beat only with a credit in hand
    assign pop_o[i] = beat_i[i].valid && (cred_q != '0);

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        cred_q  <= CRED_W'(OUT_CREDITS);
        valid_q <= 1'b0;
      end else begin
        // Spend on pop, refill on return
        cred_q  <= cred_q - CRED_W'(pop_o[i]) + CRED_W'(credit_i[i]);
        valid_q <= pop_o[i];
      end
    end

    // Beat payload
    always_ff @(posedge clk_i) begin
      if (pop_o[i]) begin
        data_q <= beat_i[i].data;
      end
    end

    assign stream_o[i].valid = valid_q;
    assign stream_o[i].data  = data_q;

    // Extra credit from the consumer would push past the start value
    a_credit_bound : assert property (@(posedge clk_i) disable iff (rst_i)
      credit_i[i] && !pop_o[i] |-> cred_q != CRED_W'(OUT_CREDITS));
  end

endmodule : stream_egress

/* verilog/streamer_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load streamer top level
// Memory must answer every accepted read once, in accept order
// Consumer returns one credit per beat, never more than OUT_CREDITS open
// A start to a busy lane is dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module streamer_top
  import streamer_pkg::*;
#(
  parameter int unsigned NUM_LANES       = 3,
  parameter int unsigned LANE_FIFO_DEPTH = 4,
  parameter int unsigned MAX_OUTSTANDING = 4,
  parameter int unsigned OUT_CREDITS     = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  // Job start, one pulse per lane
  input  logic      [NUM_LANES-1:0] start_i,
  input  lane_job_t [NUM_LANES-1:0] job_i,
  // Shared memory read port
  output mem_req_t                  mem_req_o,
  output logic                      mem_req_valid_o,
  input  logic                      mem_gnt_i,
  input  mem_rsp_t                  mem_rsp_i,
  // Output streams with credit return
  output beat_t     [NUM_LANES-1:0] stream_o,
  input  logic      [NUM_LANES-1:0] credit_i,
  output logic      [NUM_LANES-1:0] done_o
);

  // Lane side of the arbiter
  mem_req_t [NUM_LANES-1:0] lane_req;
  logic     [NUM_LANES-1:0] lane_req_valid;
  logic     [NUM_LANES-1:0] lane_gnt;
  mem_rsp_t [NUM_LANES-1:0] lane_rsp;

  // Lane side of the egress
  beat_t    [NUM_LANES-1:0] lane_beat;
  logic     [NUM_LANES-1:0] lane_pop;

  // One arbiter shared by all lanes
  mem_arbiter #(
    .NUM_LANES       ( NUM_LANES       ),
    .MAX_OUTSTANDING ( MAX_OUTSTANDING )
  ) u_mem_arbiter (
    .clk_i            ( clk_i           ),
    .rst_i            ( rst_i           ),
    .lane_req_i       ( lane_req        ),
    .lane_req_valid_i ( lane_req_valid  ),
    .lane_gnt_o       ( lane_gnt        ),
    .lane_rsp_o       ( lane_rsp        ),
    .mem_req_o        ( mem_req_o       ),
    .mem_req_valid_o  ( mem_req_valid_o ),
    .mem_gnt_i        ( mem_gnt_i       ),
    .mem_rsp_i        ( mem_rsp_i       )
  );

  // Lane 0 is X, 1 is W, 2 is Y
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
    load_lane #(
      .LANE_FIFO_DEPTH ( LANE_FIFO_DEPTH )
    ) u_load_lane (
      .clk_i       ( clk_i             ),
      .rst_i       ( rst_i             ),
      .start_i     ( start_i[i]        ),
      .job_i       ( job_i[i]          ),
      .req_o       ( lane_req[i]       ),
      .req_valid_o ( lane_req_valid[i] ),
      .gnt_i       ( lane_gnt[i]       ),
      .rsp_i       ( lane_rsp[i]       ),
      .beat_o      ( lane_beat[i]      ),
      .pop_i       ( lane_pop[i]       ),
      .done_o      ( done_o[i]         )
    );
  end

  // Credit gate and output registers
  stream_egress #(
    .NUM_LANES   ( NUM_LANES   ),
    .OUT_CREDITS ( OUT_CREDITS )
  ) u_stream_egress (
    .clk_i    ( clk_i     ),
    .rst_i    ( rst_i     ),
    .beat_i   ( lane_beat ),
    .pop_o    ( lane_pop  ),
    .stream_o ( stream_o  ),
    .credit_i ( credit_i  )
  );

endmodule : streamer_top

/* verif/tb_streamer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load streamer testbench that runs from the project root
// Memory image, jobs and expected beats come from verif/streamer_testdata.txt
// Phase 3 holds back the credits of lane 2 for a while
// Stops at the first mismatch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_streamer
  import streamer_pkg::*;
();

  localparam int unsigned NUM_LANES   = 3;
  localparam int unsigned OUT_CREDITS = 2;

  logic                      clk_i;
  logic                      rst_i;
  logic      [NUM_LANES-1:0] start_i;
  lane_job_t [NUM_LANES-1:0] job_i;
  mem_req_t                  mem_req_o;
  logic                      mem_req_valid_o;
  logic                      mem_gnt_i;
  mem_rsp_t                  mem_rsp_i;
  beat_t     [NUM_LANES-1:0] stream_o;
  logic      [NUM_LANES-1:0] credit_i;
  logic      [NUM_LANES-1:0] done_o;

  // Test data with the image at 000, job count at 080, jobs at 100 and beats at 200
  logic [31:0] td [0:1023];
  int          num_jobs;
  int          total_beats;
  int          cycle;
  logic [31:0] lcg_state;

  // Window into the expected list of each lane
  int                   lane_ptr   [NUM_LANES];
  int                   lane_end   [NUM_LANES];
  int                   lane_first [NUM_LANES];
  logic [NUM_LANES-1:0] started;
  // Beats received and not yet credited back
  int                   owed       [NUM_LANES];
  logic [NUM_LANES-1:0] withhold;

  // Reads in flight inside the memory model
  logic [31:0] rsp_data [$];
  int          rsp_due  [$];

  streamer_top #(
    .NUM_LANES       ( NUM_LANES   ),
    .LANE_FIFO_DEPTH ( 4           ),
    .MAX_OUTSTANDING ( 4           ),
    .OUT_CREDITS     ( OUT_CREDITS )
  ) u_dut (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .start_i         ( start_i         ),
    .job_i           ( job_i           ),
    .mem_req_o       ( mem_req_o       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_gnt_i       ( mem_gnt_i       ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .stream_o        ( stream_o        ),
    .credit_i        ( credit_i        ),
    .done_o          ( done_o          )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  function automatic logic [31:0] td_at(int idx);
    return td[idx[9:0]];
  endfunction

  // Background pattern built from the full address
  function automatic logic [31:0] fill_word(int unsigned a);
    return {a[15:0] ^ 16'ha5c3, a[15:0]};
  endfunction

  function automatic logic [31:0] mem_word(logic [15:0] addr);
    return (addr < 16'h0080) ? td[addr[9:0]] : fill_word({16'd0, addr});
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report(string what);
    $display("Error at %0t: %s", $time, what);
    stop_run();
  endtask

  task automatic check_beat(int lane, beat_t want, beat_t got);
    if (got !== want) begin
      $display("FAILED at %0t: stream_o[%0d] expected %h got %h", $time, lane, want, got);
      stop_run();
    end
  endtask

  task automatic check_done(int lane, logic want, logic got);
    if (got !== want) begin
      $display("FAILED at %0t: done_o[%0d] expected %b got %b", $time, lane, want, got);
      stop_run();
    end
  endtask

  task automatic check_req_valid(logic want, logic got);
    if (got !== want) begin
      $display("FAILED at %0t: mem_req_valid_o expected %b got %b", $time, want, got);
      stop_run();
    end
  endtask

  // Beat order per lane, the credit bound and done right after the last beat
  task automatic watch_outputs();
    beat_t want;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (stream_o[l].valid) begin
        if (lane_ptr[l] == lane_end[l]) begin
          report($sformatf("lane %0d sent a beat beyond its expected list", l));
        end
        want.valid = 1'b1;
        want.data  = td_at(lane_ptr[l]);
        check_beat(l, want, stream_o[l]);
        lane_ptr[l]++;
        owed[l]++;
        if (owed[l] > int'(OUT_CREDITS)) begin
          report($sformatf("lane %0d has more unanswered beats than credits", l));
        end
      end
      check_done(l, started[l] && (lane_ptr[l] == lane_end[l]), done_o[l]);
    end
  endtask

  // In-order reads with the grant low about one cycle in four and latency 1 to 4
  task automatic serve_memory();
    int due;
    mem_rsp_i = '0;
    if (rsp_due.size() != 0 && rsp_due[0] <= cycle) begin
      mem_rsp_i.valid = 1'b1;
      mem_rsp_i.rdata = rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
    mem_gnt_i = !rst_i && (next_rand() % 4 != 0);
    if (mem_gnt_i && mem_req_valid_o) begin
      due = cycle + 1 + int'(next_rand() % 4);
      if (rsp_due.size() != 0 && due <= rsp_due[$]) begin
        due = rsp_due[$] + 1;
      end
      rsp_data.push_back(mem_word(mem_req_o.addr));
      rsp_due.push_back(due);
    end
  endtask

  task automatic return_credits();
    for (int l = 0; l < NUM_LANES; l++) begin
      credit_i[l] = 1'b0;
      if (!withhold[l] && owed[l] != 0 && next_rand() % 3 == 0) begin
        credit_i[l] = 1'b1;
        owed[l]--;
      end
    end
  endtask

  // One clock with all sampling and driving on the falling edge
  task automatic tick();
    @(negedge clk_i);
    cycle++;
    if (!rst_i) begin
      watch_outputs();
    end
    serve_memory();
    return_credits();
  endtask

  // Start every job of a phase in the same cycle
  task automatic launch(int ph);
    int p;
    int l;
    for (int j = 0; j < num_jobs; j++) begin
      p = 'h100 + 8 * j;
      if (td_at(p) == ph) begin
        l = int'(td_at(p + 1));
        start_i[l]       = 1'b1;
        job_i[l].fmt     = (td_at(p + 2) != 32'd0) ? FMT_FP16 : FMT_FP32;
        job_i[l].len     = 8'(td_at(p + 3));
        job_i[l].base    = 16'(td_at(p + 4));
        job_i[l].stride  = 16'(td_at(p + 5));
        lane_ptr[l]      = int'(td_at(p + 6));
        lane_first[l]    = lane_ptr[l];
        lane_end[l]      = lane_ptr[l] + int'(td_at(p + 7));
        started[l]       = 1'b1;
      end
    end
    tick();
    start_i = '0;
  endtask

  task automatic wait_lanes(logic [NUM_LANES-1:0] mask);
    logic busy;
    busy = 1'b1;
    while (busy) begin
      tick();
      busy = 1'b0;
      for (int l = 0; l < NUM_LANES; l++) begin
        if (mask[l] && lane_ptr[l] != lane_end[l]) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  initial begin
    rst_i     = 1'b1;
    start_i   = '0;
    job_i     = '0;
    mem_gnt_i = 1'b0;
    mem_rsp_i = '0;
    credit_i  = '0;
    lcg_state = 32'd78;
    cycle     = 0;
    started   = '0;
    withhold  = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_ptr[l]   = 0;
      lane_end[l]   = 0;
      lane_first[l] = 0;
      owed[l]       = 0;
    end
    for (int i = 0; i < 1024; i++) begin
      td[i] = fill_word(i);
    end
    $readmemh("verif/streamer_testdata.txt", td);
    num_jobs    = int'(td_at('h080));
    total_beats = 0;
    for (int j = 0; j < num_jobs; j++) begin
      total_beats += int'(td_at('h107 + 8 * j));
    end

    repeat (8) tick();
    rst_i = 1'b0;
    // Quiet outputs before any start
    repeat (10) begin
      tick();
      check_req_valid(1'b0, mem_req_valid_o);
    end

    // FP32 on lane 0 and then FP16 with stride 2 on lane 1
    launch(1);
    wait_lanes('1);
    repeat (4) tick();
    launch(2);
    wait_lanes('1);
    repeat (4) tick();

    // All lanes together with lane 2 starved of credits at first
    withhold[2] = 1'b1;
    launch(3);
    repeat (2) tick();
    // Lane 0 is busy here so this job must be dropped
    start_i[0] = 1'b1;
    job_i[0]   = '{base: 16'h0010, stride: 16'h0001, len: 8'd1, fmt: FMT_FP32};
    tick();
    start_i = '0;
    wait_lanes(3'b011);
    repeat (20) tick();
    if (lane_ptr[2] != lane_first[2] + int'(OUT_CREDITS)) begin
      report("lane 2 did not stop at its credit limit");
    end
    withhold[2] = 1'b0;
    wait_lanes(3'b111);
    repeat (20) tick();

    $display("Everything OK");
    $finish;
  end

  // Run limit scales with the number of expected beats
  initial begin
    @(posedge clk_i);
    repeat (40 * total_beats + 200) @(posedge clk_i);
    $display("Timeout, the expected beats did not all arrive in time");
    stop_run();
  end

endmodule : tb_streamer

/* verif/streamer_testdata.txt */
// Load streamer test data, hex words, addresses set by @ lines
// 000-07f memory image, 080 job count, 100 job table, 200 expected beats
// Job columns: phase lane fmt(0 fp32, 1 fp16) len base stride exp_ptr exp_cnt
@000
3f800000 40000000 c0490fdb 12345678
@010
// FP16 pairs with the high half in the upper bits, odd words never read
3c000000 deadbeef 80017c00 deadbeef c5007e01
@020
11111111 22222222 33333333 44444444 55555555 66666666
@030
bc004000 deadbeef deadbeef 03fffc00
@03b
// Walked downwards from 03f with stride ffff
a0000005 a0000004 a0000003 a0000002 a0000001
@080
00000005
@100
00000001 00000000 00000000 00000004 00000000 00000001 00000200 00000004
00000002 00000001 00000001 00000003 00000010 00000002 00000204 00000006
00000003 00000000 00000000 00000006 00000020 00000001 0000020a 00000006
00000003 00000001 00000001 00000002 00000030 00000003 00000210 00000004
00000003 00000002 00000000 00000005 0000003f 0000ffff 00000214 00000005
@200
// Phase 1 lane 0, words as stored
3f800000 40000000 c0490fdb 12345678
// Phase 2 lane 1 gives zero, one, +inf, -0 from a subnormal, NaN and -5
00000000 3f800000 7f800000 80000000 7fc02000 c0a00000
// Phase 3 lane 0
11111111 22222222 33333333 44444444 55555555 66666666
// Phase 3 lane 1 gives two, minus one, -inf and a flushed subnormal
40000000 bf800000 ff800000 00000000
// Phase 3 lane 2 in descending address order
a0000001 a0000002 a0000003 a0000004 a0000005

/* all.f */
common/streamer_pkg.sv
load/fp_castin.sv
load/lane_fifo.sv
load/load_lane.sv
verilog/mem_arbiter.sv
verilog/stream_egress.sv
verilog/streamer_top.sv
verif/tb_streamer.sv

/* Makefile */
# Verilator flow for the load streamer
VERILATOR  ?= verilator
TOP        := tb_streamer
RTL_TOP    := streamer_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Everything OK
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
